//--- cft_mbu.f
cft_mbu_pkg.sv
mbu_control.sv
mbu_bank_file.sv
mbu_aext_gen.sv
cft_mbu.sv
tb_cft_mbu_properties.sv
tb_cft_mbu.sv

//--- Bender.yml
package:
  name: cft_mbu

sources:
  - files:
      - cft_mbu_pkg.sv
      - mbu_control.sv
      - mbu_bank_file.sv
      - mbu_aext_gen.sv
      - cft_mbu.sv
  - target: test
    files:
      - tb_cft_mbu_properties.sv
      - tb_cft_mbu.sv

//--- tb_cft_mbu.sv
`timescale 1ns/1ns

module tb_cft_mbu import cft_mbu_pkg::*; ();

   localparam int unsigned RESET_CYC   = 16;
   localparam int unsigned N_MIXED     = 300;   // Random transfers at the end
   localparam int unsigned ACK_WAIT    = 4;     // Cycles allowed for an ack
   localparam int unsigned TIMEOUT_CYC = 4000;  // About twice the ~2000 cycles of all phases

   logic     clk4     = 1'b0;
   logic     arst_n   = 1'b0;
   logic     wb_cyc   = 1'b0;
   logic     wb_stb   = 1'b0;
   logic     wb_we    = 1'b0;
   wb_adr_t  wb_adr   = '0;
   mb_data_t wb_dat_w = '0;
   mb_data_t wb_dat_r;
   logic     wb_ack;
   mb_sel_t  mb_sel   = '0;
   mb_data_t aext;
   logic     ram_rom  = 1'b0;
   logic     mbu_en;

   integer   seed = 32'h674b;

   // Reference model
   mb_data_t ref_mem   [2**CTX_W][N_BANKS];
   bit       ref_known [2**CTX_W][N_BANKS];  // Bank written since reset
   ctx_t     ref_ctx = '0;
   logic     ref_en  = 1'b0;

   // Write taken by the driver, folded into the model at the next edge
   logic     pend_bank = 1'b0;
   logic     pend_ctx  = 1'b0;
   mb_sel_t  pend_sel  = '0;
   mb_data_t pend_dat  = '0;

   mb_sel_t  sel_hist;                // Selector sampled at the previous edge
   logic     hist_valid = 1'b0;
   mb_data_t exp_aext;
   logic     exp_valid  = 1'b0;
   logic     exp_skip   = 1'b0;       // Lookup hit an unwritten bank
   int unsigned cycle_cnt = 0;

   always #5 clk4 = ~clk4;            // 10 ns period

   cft_mbu u_dut (
      .clk4     (clk4),
      .arst_n   (arst_n),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_w (wb_dat_w),
      .wb_dat_r (wb_dat_r),
      .wb_ack   (wb_ack),
      .mb_sel   (mb_sel),
      .aext     (aext),
      .ram_rom  (ram_rom),
      .mbu_en   (mbu_en)
   );

   ////////////////////
   // Checks
   ////////////////////

   task automatic stop_on_error();
      $display("Finished with errors");
      $fatal(1, "Simulation stopped at first error");
   endtask

   task automatic check_data(input string name, input mb_data_t got, input mb_data_t exp);
      if (got !== exp) begin
         $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
         stop_on_error();
      end
   endtask

   task automatic check_ctx(input string name, input ctx_t got, input ctx_t exp);
      if (got !== exp) begin
         $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
         stop_on_error();
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
         stop_on_error();
      end
   endtask

   // Expected aext for one lookup
   function automatic mb_data_t ref_aext(input mb_sel_t sel, input ctx_t c, input logic en,
                                         input logic sw);
      mb_data_t dft;
      dft = '0;
      dft[DATA_W-1] = sw;              // RAM/ROM switch on top
      if (en) begin
         return ref_mem[c][sel];
      end
      return dft;
   endfunction

   ////////////////////
   // Bus driver
   ////////////////////

   // Called and returns on a falling edge
   task automatic bus_xfer(input logic we, input wb_adr_t adr, input mb_data_t wdat,
                           output mb_data_t rdat);
      int unsigned n;
      n        = 0;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_w = wdat;
      do begin
         @(negedge clk4);
         n++;
      end while (!wb_ack && n < ACK_WAIT);
      if (!wb_ack) begin
         $display("No ack within %0d cycles for address %0d", ACK_WAIT, adr);
         stop_on_error();
      end
      rdat   = wb_dat_r;                // Valid while ack is high
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
      if (we && adr < N_BANKS) begin
         pend_sel  = adr[SEL_W-1:0];
         pend_dat  = wdat;
         pend_bank = 1'b1;
      end else if (we && adr == ADR_CTX) begin
         pend_dat = wdat;
         pend_ctx = 1'b1;
      end                              // Unmapped writes change nothing
      @(negedge clk4);
      if (wb_ack) begin
         $display("Second ack for one transfer at address %0d", adr);
         stop_on_error();
      end
      check_flag("mbu_en", mbu_en, ref_en);
   endtask

   task automatic bus_write(input wb_adr_t adr, input mb_data_t dat);
      mb_data_t unused;
      bus_xfer(1'b1, adr, dat, unused);
   endtask

   task automatic bus_read_check(input wb_adr_t adr);
      mb_data_t rdat;
      bus_xfer(1'b0, adr, mb_data_t'($random(seed)), rdat);  // Junk on dat_w
      if (adr == ADR_CTX) begin
         check_ctx("wb_dat_r", ctx_t'(rdat), ref_ctx);
      end else if (adr >= N_BANKS) begin
         check_data("wb_dat_r", rdat, '0);
      end else if (ref_known[ref_ctx][adr[SEL_W-1:0]]) begin
         check_data("wb_dat_r", rdat, ref_mem[ref_ctx][adr[SEL_W-1:0]]);
      end
   endtask

   ////////////////////
   // Lookup stimulus and compare
   ////////////////////

   always @(negedge clk4) begin
      mb_sel  = mb_sel_t'($random(seed));  // New selector every cycle
      ram_rom = 1'($random(seed));
   end

   // Expected value for the lookup of the previous edge, then model update
   always @(posedge clk4) begin
      if (!arst_n) begin
         hist_valid = 1'b0;
         exp_valid  = 1'b0;
      end else begin
         if (hist_valid) begin
            exp_aext  = ref_aext(sel_hist, ref_ctx, ref_en, ram_rom);
            exp_skip  = ref_en && !ref_known[ref_ctx][sel_hist];
            exp_valid = 1'b1;
         end
         if (pend_bank) begin
            ref_mem[ref_ctx][pend_sel]   = pend_dat;
            ref_known[ref_ctx][pend_sel] = 1'b1;
            ref_en    = 1'b1;          // First bank write enables
            pend_bank = 1'b0;
         end
         if (pend_ctx) begin
            ref_ctx  = ctx_t'(pend_dat);
            pend_ctx = 1'b0;
         end
         sel_hist   = mb_sel;
         hist_valid = 1'b1;
      end
   end

   always @(negedge clk4) begin
      if (exp_valid && !exp_skip) begin
         check_data("aext", aext, exp_aext);
      end
   end

   // Run limit and assertion watch
   always @(negedge clk4) begin
      cycle_cnt++;
      if (cycle_cnt > TIMEOUT_CYC) begin
         $display("Run did not finish within %0d cycles", TIMEOUT_CYC);
         stop_on_error();
      end else if (u_dut.u_props.fail_cnt != 0) begin
         $display("A concurrent assertion on the DUT failed");
         stop_on_error();
      end
   end

   ////////////////////
   // Sequence
   ////////////////////

   initial begin
      int unsigned i;
      int unsigned c;
      wb_adr_t     a;
      mb_data_t    d;
      repeat (RESET_CYC) @(negedge clk4);
      arst_n = 1'b1;

      // Disabled unit, context write keeps it off
      repeat (30) @(negedge clk4);
      bus_write(ADR_CTX, mb_data_t'($random(seed)));
      bus_read_check(ADR_CTX);
      repeat (20) @(negedge clk4);
      bus_write(ADR_CTX, 8'h00);

      // First bank write enables, lookups follow
      for (i = 0; i < N_BANKS; i++) begin
         bus_write(wb_adr_t'(i), mb_data_t'($random(seed)));
      end
      repeat (40) @(negedge clk4);
      for (i = 0; i <= ADR_CTX; i++) begin
         bus_read_check(wb_adr_t'(i));
      end

      // Fill contexts 1..3 then revisit all of them
      for (c = 1; c < 4; c++) begin
         bus_write(ADR_CTX, mb_data_t'(c));
         for (i = 0; i < N_BANKS; i++) begin
            bus_write(wb_adr_t'(i), mb_data_t'($random(seed)));
         end
         for (i = 0; i < N_BANKS; i++) begin
            bus_read_check(wb_adr_t'(i));
         end
         repeat (20) @(negedge clk4);
      end
      for (c = 0; c < 4; c++) begin
         bus_write(ADR_CTX, mb_data_t'(c));
         for (i = 0; i <= ADR_CTX; i++) begin
            bus_read_check(wb_adr_t'(i));
         end
         repeat (10) @(negedge clk4);
      end

      // Unmapped space
      for (i = ADR_CTX + 1; i < 2**WB_ADR_W; i++) begin
         bus_write(wb_adr_t'(i), mb_data_t'($random(seed)));
         bus_read_check(wb_adr_t'(i));
      end
      for (i = 0; i <= ADR_CTX; i++) begin
         bus_read_check(wb_adr_t'(i));
      end

      // Mixed random traffic
      for (i = 0; i < N_MIXED; i++) begin
         a = wb_adr_t'($random(seed));
         d = mb_data_t'($random(seed));
         if (a == ADR_CTX) begin
            d = d & 8'h03;             // Contexts with all banks written
         end
         if (1'($random(seed))) begin
            bus_write(a, d);
         end else begin
            bus_read_check(a);
         end
      end
      repeat (4) @(negedge clk4);      // Drain the lookup pipeline

      if (u_dut.u_props.fail_cnt != 0) begin
         $display("A concurrent assertion on the DUT failed");
         stop_on_error();
      end else begin
         $display("Finished with no errors");
         $finish;
      end
   end

endmodule

//--- tb_cft_mbu_properties.sv
`timescale 1ns/1ns

module tb_cft_mbu_properties import cft_mbu_pkg::*; (
   input logic     clk4,
   input logic     arst_n,
   input logic     wb_cyc,
   input logic     wb_stb,
   input logic     wb_ack,
   input logic     mbu_en,
   input logic     ram_rom,
   input mb_data_t aext
);

   int unsigned fail_cnt = 0;  // Watched by the testbench

   ////////////////////
   // Wishbone handshake
   ////////////////////

   ack_single: assert property (@(posedge clk4) disable iff (!arst_n)
      wb_ack |=> !wb_ack)
      else begin
         fail_cnt++;
         $error("wb_ack high for two cycles in a row");
      end

   ack_in_cycle: assert property (@(posedge clk4) disable iff (!arst_n)
      wb_ack |-> $past(wb_cyc && wb_stb))  // Ack only answers a live cycle
      else begin
         fail_cnt++;
         $error("wb_ack without a preceding cycle");
      end

   ////////////////////
   // Enable and aext
   ////////////////////

   en_sticky: assert property (@(posedge clk4) disable iff (!arst_n)
      mbu_en |=> mbu_en)
      else begin
         fail_cnt++;
         $error("mbu_en fell outside reset");
      end

   // Lookup result lags the enable by two samples
   aext_default: assert property (@(posedge clk4) disable iff (!arst_n)
      ($past(arst_n) && !$past(mbu_en, 2)) |->
         aext == mb_data_t'({$past(ram_rom), {(DATA_W-1){1'b0}}}))
      else begin
         fail_cnt++;
         $error("aext not at power-on default while disabled");
      end

endmodule

bind cft_mbu tb_cft_mbu_properties u_props (
   .clk4    (clk4),
   .arst_n  (arst_n),
   .wb_cyc  (wb_cyc),
   .wb_stb  (wb_stb),
   .wb_ack  (wb_ack),
   .mbu_en  (mbu_en),
   .ram_rom (ram_rom),
   .aext    (aext)
);

//--- cft_mbu.sv
`timescale 1ns/1ns

module cft_mbu import cft_mbu_pkg::*; (
   input  logic     clk4,      // Unit clock
   input  logic     arst_n,    // Async reset, active low

   // Wishbone classic slave
   input  logic     wb_cyc,
   input  logic     wb_stb,
   input  logic     wb_we,
   input  wb_adr_t  wb_adr,    // 0..7 MBn, 8 context
   input  mb_data_t wb_dat_w,
   output mb_data_t wb_dat_r,
   output logic     wb_ack,

   // Translation port
   input  mb_sel_t  mb_sel,    // IR index field
   output mb_data_t aext,      // Extended address byte

   input  logic     ram_rom,   // Front panel switch
   output logic     mbu_en     // Panel LED
);

   logic     bank_we;
   mb_sel_t  bank_sel;
   logic     ctx_we;
   mb_data_t wr_data;
   mb_data_t bank_rdata;
   ctx_t     ctx;
   mb_data_t xlat_data;

   ////////////////////
   // Bus side
   ////////////////////

   mbu_control u_control (
      .clk4       (clk4),
      .arst_n     (arst_n),
      .wb_cyc     (wb_cyc),
      .wb_stb     (wb_stb),
      .wb_we      (wb_we),
      .wb_adr     (wb_adr),
      .wb_dat_w   (wb_dat_w),
      .wb_dat_r   (wb_dat_r),
      .wb_ack     (wb_ack),
      .bank_rdata (bank_rdata),
      .ctx        (ctx),
      .bank_we    (bank_we),
      .bank_sel   (bank_sel),
      .ctx_we     (ctx_we),
      .wr_data    (wr_data),
      .mbu_en     (mbu_en)
   );

   ////////////////////
   // Datapath
   ////////////////////

   mbu_bank_file u_bank_file (
      .clk4       (clk4),
      .arst_n     (arst_n),
      .bank_we    (bank_we),
      .bank_sel   (bank_sel),
      .ctx_we     (ctx_we),
      .wr_data    (wr_data),
      .mb_sel     (mb_sel),      // Sampled every edge
      .bank_rdata (bank_rdata),
      .xlat_data  (xlat_data),
      .ctx        (ctx)
   );

   mbu_aext_gen u_aext_gen (
      .clk4       (clk4),
      .arst_n     (arst_n),
      .mbu_en     (mbu_en),
      .ram_rom    (ram_rom),
      .xlat_data  (xlat_data),
      .aext       (aext)         // Two edges after mb_sel reaches the lookup
   );

endmodule

//--- mbu_aext_gen.sv
`timescale 1ns/1ns

module mbu_aext_gen import cft_mbu_pkg::*; (
   input  logic     clk4,       // Unit clock
   input  logic     arst_n,     // Async reset, active low
   input  logic     mbu_en,     // Unit enable from control
   input  logic     ram_rom,    // Front panel RAM/ROM switch
   input  mb_data_t xlat_data,  // Bank file lookup, one clock after mb_sel
   output mb_data_t aext        // Extended address byte
);

   logic     en_d;      // Enable as seen when the selector was sampled
   mb_data_t aext_dft;  // Power-on value of aext

   // Switch in the top bit, zeros below
   assign aext_dft = {ram_rom, {(DATA_W-1){1'b0}}};

   ////////////////////
   // Output stage
   ////////////////////

   // xlat_data lags mb_sel by one edge
   // en_d lags mbu_en by the same amount so each lookup
   // uses the enable that was current when its selector was taken
   always_ff @(posedge clk4 or negedge arst_n) begin
      if (!arst_n) begin
         en_d <= 1'b0;
         aext <= '0;          // Zero until the first edge after reset
      end else begin
         en_d <= mbu_en;
         if (en_d) begin
            aext <= xlat_data;  // Translated bank
         end else begin
            aext <= aext_dft;   // Unit still disabled
         end
      end
   end

endmodule

//--- mbu_bank_file.sv
`timescale 1ns/1ns

module mbu_bank_file import cft_mbu_pkg::*; (
   input  logic     clk4,        // Unit clock
   input  logic     arst_n,      // Async reset, clears the context only

   // Write port, shared by banks and context
   input  logic     bank_we,     // Write MBn of the current context
   input  mb_sel_t  bank_sel,    // MBn for the Wishbone port
   input  logic     ctx_we,      // Load the context register
   input  mb_data_t wr_data,

   // Translation lookup
   input  mb_sel_t  mb_sel,      // Bank selector from the IR index field

   output mb_data_t bank_rdata,  // Wishbone read port, one clock after address
   output mb_data_t xlat_data,   // Translation read port, one clock after mb_sel
   output ctx_t     ctx          // Current context
);

   mb_data_t  mem [BANK_DEPTH];  // 256 contexts x 8 banks
   bank_adr_t wb_bank_adr;       // Wishbone write and read address
   bank_adr_t xl_bank_adr;       // Translation read address

   // Both ports index into the current context
   assign wb_bank_adr = {ctx, bank_sel};
   assign xl_bank_adr = {ctx, mb_sel};

   ////////////////////
   // Context register
   ////////////////////

   always_ff @(posedge clk4 or negedge arst_n) begin
      if (!arst_n) begin
         ctx <= '0;                    // Context 0 after reset
      end else if (ctx_we) begin
         ctx <= ctx_t'(wr_data);
      end
   end

   ////////////////////
   // Bank storage
   ////////////////////

   // Single write port
   // Contents are undefined until software writes them
   always_ff @(posedge clk4) begin
      if (bank_we) begin
         mem[wb_bank_adr] <= wr_data;
      end
   end

   // Wishbone read port
   // Old data on a same-edge write
   always_ff @(posedge clk4) begin
      bank_rdata <= mem[wb_bank_adr];
   end

   // Translation read port, new selector every cycle
   always_ff @(posedge clk4) begin
      xlat_data <= mem[xl_bank_adr];
   end

endmodule

//--- mbu_control.sv
`timescale 1ns/1ns

module mbu_control import cft_mbu_pkg::*; (
   input  logic     clk4,        // Unit clock
   input  logic     arst_n,      // Async reset, active low

   // Wishbone classic slave
   input  logic     wb_cyc,
   input  logic     wb_stb,
   input  logic     wb_we,
   input  wb_adr_t  wb_adr,
   input  mb_data_t wb_dat_w,
   output mb_data_t wb_dat_r,
   output logic     wb_ack,

   // Bank file side
   input  mb_data_t bank_rdata,  // Synchronous read of MBn at bank_sel
   input  ctx_t     ctx,         // Current context
   output logic     bank_we,     // Write MBn of current context
   output mb_sel_t  bank_sel,    // Which MBn
   output logic     ctx_we,      // Write context register
   output mb_data_t wr_data,     // Data for either write

   output logic     mbu_en       // Unit enable, also the panel LED
);

   logic     cyc_act;    // Master has a cycle on the bus
   logic     seen_q;     // Cycle accepted, ack due at the next edge
   logic     xfer_we;    // Write phase of an accepted cycle
   logic     hit_bank;   // Address is MB0..MB7
   logic     hit_ctx;    // Address is the context register
   rd_src_e  rd_src_q;   // Read mux select, aligned with ack
   ctx_t     ctx_q;      // Context snapshot for reads of address 8

   ////////////////////
   // Address decode
   ////////////////////

   assign cyc_act  = wb_cyc & wb_stb;
   assign hit_bank = (wb_adr < wb_adr_t'(N_BANKS));
   assign hit_ctx  = (wb_adr == ADR_CTX);
   // Anything else is unmapped

   assign bank_sel = wb_adr[SEL_W-1:0];  // Low bits pick MBn
   assign wr_data  = wb_dat_w;

   ////////////////////
   // Handshake
   ////////////////////

   // Edge N sees the cycle and sets seen_q
   // Edge N+1 raises ack for exactly one cycle
   // Neither bit can restart while the other is set, so a held stb
   // does not produce a second ack
   always_ff @(posedge clk4 or negedge arst_n) begin
      if (!arst_n) begin
         seen_q <= 1'b0;
         wb_ack <= 1'b0;
      end else begin
         seen_q <= cyc_act & ~seen_q & ~wb_ack;
         wb_ack <= seen_q & cyc_act;  // Master abort drops the ack
      end
   end

   // Strobes live in the cycle between seen and ack
   // so the write lands on the edge that raises ack
   assign xfer_we = seen_q & cyc_act & wb_we;
   assign bank_we = xfer_we & hit_bank;
   assign ctx_we  = xfer_we & hit_ctx;   // Unmapped writes go nowhere

   ////////////////////
   // Read path
   ////////////////////

   // The bank file reads at the edge that raises ack
   // Select and context are registered on that same edge to match
   always_ff @(posedge clk4 or negedge arst_n) begin
      if (!arst_n) begin
         rd_src_q <= RD_NONE;
      end else if (seen_q && !wb_we) begin
         if (hit_bank) begin
            rd_src_q <= RD_BANK;
         end else if (hit_ctx) begin
            rd_src_q <= RD_CTX;
         end else begin
            rd_src_q <= RD_NONE;  // Unmapped reads return zero
         end
      end else begin
         rd_src_q <= RD_NONE;
      end
   end

   always_ff @(posedge clk4) begin
      if (seen_q) begin
         ctx_q <= ctx;  // Snapshot only when a transfer is in progress
      end
   end

   // Data is meaningful only while wb_ack is high
   always_comb begin
      unique case (rd_src_q)
         RD_BANK: wb_dat_r = bank_rdata;
         RD_CTX:  wb_dat_r = mb_data_t'(ctx_q);
         default: wb_dat_r = '0;
      endcase
   end

   ////////////////////
   // Enable flag
   ////////////////////

   // Any bank write brings the unit out of its power-on state
   // Context writes leave it alone
   always_ff @(posedge clk4 or negedge arst_n) begin
      if (!arst_n) begin
         mbu_en <= 1'b0;
      end else if (bank_we) begin
         mbu_en <= 1'b1;  // Sticky until the next reset
      end
   end

endmodule

//--- cft_mbu_pkg.sv
package cft_mbu_pkg;

   ////////////////////
   // Widths
   ////////////////////

   localparam int unsigned DATA_W   = 8;  // Bank register and bus data byte
   localparam int unsigned CTX_W    = 8;  // Context register
   localparam int unsigned SEL_W    = 3;  // Bank selector from the IR index field
   localparam int unsigned WB_ADR_W = 4;  // Wishbone word address

   // Bank storage is indexed by {context, bank}
   localparam int unsigned BANK_ADR_W = CTX_W + SEL_W;
   localparam int unsigned BANK_DEPTH = 2 ** BANK_ADR_W;  // 2048 entries
   localparam int unsigned N_BANKS    = 2 ** SEL_W;       // MB0..MB7 per context

   ////////////////////
   // Types
   ////////////////////

   typedef logic [DATA_W-1:0]     mb_data_t;   // One bank register or data byte
   typedef logic [CTX_W-1:0]      ctx_t;       // Context number
   typedef logic [SEL_W-1:0]      mb_sel_t;    // Bank selector
   typedef logic [WB_ADR_W-1:0]   wb_adr_t;    // Wishbone word address
   typedef logic [BANK_ADR_W-1:0] bank_adr_t;  // Flat bank storage address

   // Source of the Wishbone read data during ack
   typedef enum logic [1:0] {
      RD_NONE = 2'd0,  // Unmapped or write cycle, reads as zero
      RD_BANK = 2'd1,  // MB0..MB7 of the current context
      RD_CTX  = 2'd2   // Context register
   } rd_src_e;

   ////////////////////
   // Register map
   ////////////////////

   // 0..7 are MB0..MB7, 8 is the context register
   // 9..15 are unmapped and ack with zero data
   localparam wb_adr_t ADR_CTX = wb_adr_t'(8);

endpackage
